/* src/tile_pkg.sv */
/*
 * Compute tile package
 * Wishbone request/response and NoC flit structs, the tile address map,
 * memory sizes and the network adapter register offsets
 */
package tile_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;

   localparam int NR_MASTERS = 2;
   localparam int NR_SLAVES  = 3;
   localparam int MST_IDX_W  = $clog2(NR_MASTERS);

   localparam int SLV_SRAM = 0;
   localparam int SLV_NA   = 1;
   localparam int SLV_ROM  = 2;

   localparam logic [3:0] NA_MATCH  = 4'hE; // Top nibble of adapter region
   localparam logic [3:0] ROM_MATCH = 4'hF;

   localparam int LMEM_WORDS = 256;
   localparam int LMEM_AW    = $clog2(LMEM_WORDS);
   localparam int ROM_WORDS  = 16;
   localparam int ROM_AW     = $clog2(ROM_WORDS);
   localparam logic [DATA_W-1:0] ROM_TAG = 32'hB007_0000;

   localparam int NA_FIFO_DEPTH = 4;

   // Adapter register byte offsets
   localparam logic [3:0] REG_TX      = 4'h0;
   localparam logic [3:0] REG_TX_LAST = 4'h4;
   localparam logic [3:0] REG_RX      = 4'h8;
   localparam logic [3:0] REG_STATUS  = 4'hC;

   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   typedef struct packed {
      logic              last;    // Marks the final flit of a message
      logic [DATA_W-1:0] payload;
   } flit_t;

endpackage

/* src/flit_fifo.sv */
/*
 * Flit FIFO
 * Small synchronous circular buffer, head visible without a pop
 */
`timescale 1ns/100ps

module flit_fifo #(
   parameter int DEPTH = tile_pkg::NA_FIFO_DEPTH
) (
   input  logic            clk,
   input  logic            rst_i,
   input  logic            push_i,
   input  tile_pkg::flit_t flit_i,
   output logic            full_o,
   input  logic            pop_i,
   output tile_pkg::flit_t flit_o,
   output logic            empty_o
);

   tile_pkg::flit_t              mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
   logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
   logic [$clog2(DEPTH+1)-1:0]   count_q;

   assign full_o  = (count_q == DEPTH);
   assign empty_o = (count_q == '0);
   assign flit_o  = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr_q] <= flit_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q; // Both or neither
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst_i)
      !(push_i && full_o) && !(pop_i && empty_o))
      else $error("FIFO overflow or underflow");

endmodule

/* src/wb_arbiter.sv */
/*
 * Wishbone round-robin arbiter
 * Grants the shared tile bus to one master at a time and keeps the
 * grant until that master drops cyc
 */
`timescale 1ns/100ps

module wb_arbiter (
   input  logic                                        clk,
   input  logic                                        rst_i,
   input  tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] m_req_i,
   output tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] m_rsp_o,
   output tile_pkg::wb_req_t                           bus_req_o,
   input  tile_pkg::wb_rsp_t                           bus_rsp_i
);

   logic [tile_pkg::NR_MASTERS-1:0] grant_q;   // One-hot, zero when idle
   logic [tile_pkg::MST_IDX_W-1:0]  last_q;    // Last winner
   logic [tile_pkg::NR_MASTERS-1:0] cyc_vec;
   logic [tile_pkg::NR_MASTERS-1:0] next_gnt;
   logic [tile_pkg::MST_IDX_W-1:0]  next_idx;
   logic                            found;
   logic                            release_bus;
   int                              cand;

   always_comb begin
      for (int i = 0; i < tile_pkg::NR_MASTERS; i++) begin
         cyc_vec[i] = m_req_i[i].cyc;
      end
   end

   assign release_bus = ~|(grant_q & cyc_vec); // Idle or owner left

   // Search starts just after the last winner
   always_comb begin
      next_gnt = '0;
      next_idx = last_q;
      found    = 1'b0;
      cand     = 0;
      for (int k = 1; k <= tile_pkg::NR_MASTERS; k++) begin
         cand = (int'(last_q) + k) % tile_pkg::NR_MASTERS;
         if (!found && cyc_vec[cand]) begin
            found          = 1'b1;
            next_gnt[cand] = 1'b1;
            next_idx       = cand[tile_pkg::MST_IDX_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         grant_q <= '0;
         last_q  <= '1;
      end else if (release_bus) begin
         grant_q <= next_gnt;
         if (found) begin
            last_q <= next_idx;
         end
      end
   end

   always_comb begin
      bus_req_o = '0;
      for (int i = 0; i < tile_pkg::NR_MASTERS; i++) begin
         if (grant_q[i]) begin
            bus_req_o = m_req_i[i];
         end
         m_rsp_o[i] = grant_q[i] ? bus_rsp_i : '0; // Only the owner sees ack/err
      end
   end

   for (genvar g = 0; g < tile_pkg::NR_MASTERS; g++) begin : gen_gnt_chk
      assert property (@(posedge clk) disable iff (rst_i)
         grant_q[g] && !m_req_i[g].cyc |=> !grant_q[g])
         else $error("Grant kept by idle master %0d", g);
   end

endmodule

/* src/wb_decoder.sv */
/*
 * Tile address decoder
 * Routes the granted request to SRAM, network adapter or boot ROM and
 * answers unmapped addresses with a one-cycle error
 */
`timescale 1ns/100ps

module wb_decoder (
   input  logic                                       clk,
   input  logic                                       rst_i,
   input  tile_pkg::wb_req_t                          bus_req_i,
   output tile_pkg::wb_rsp_t                          bus_rsp_o,
   output tile_pkg::wb_req_t [tile_pkg::NR_SLAVES-1:0] slv_req_o,
   input  tile_pkg::wb_rsp_t [tile_pkg::NR_SLAVES-1:0] slv_rsp_i
);

   logic [tile_pkg::NR_SLAVES-1:0] sel;
   logic [tile_pkg::NR_SLAVES-1:0] slv_stb;
   logic [3:0]                     top_nibble;
   logic                           miss;
   logic                           err_q;

   assign top_nibble = bus_req_i.adr[tile_pkg::ADDR_W-1 -: 4];

   // Regions compared in parallel, the map keeps them disjoint
   assign sel[tile_pkg::SLV_SRAM] = ~bus_req_i.adr[tile_pkg::ADDR_W-1]; // Lower half
   assign sel[tile_pkg::SLV_NA]   = (top_nibble == tile_pkg::NA_MATCH);
   assign sel[tile_pkg::SLV_ROM]  = (top_nibble == tile_pkg::ROM_MATCH);

   always_comb begin
      for (int s = 0; s < tile_pkg::NR_SLAVES; s++) begin
         slv_stb[s]       = bus_req_i.stb & sel[s];
         slv_req_o[s]     = bus_req_i;
         slv_req_o[s].stb = slv_stb[s];
      end
   end

   assign miss = bus_req_i.cyc & bus_req_i.stb & ~|sel;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= miss & ~err_q; // Single-cycle error for holes in the map
      end
   end

   always_comb begin
      bus_rsp_o     = '0;
      bus_rsp_o.err = err_q;
      for (int s = 0; s < tile_pkg::NR_SLAVES; s++) begin
         if (sel[s]) begin
            bus_rsp_o.dat = slv_rsp_i[s].dat;
         end
         bus_rsp_o.ack = bus_rsp_o.ack | slv_rsp_i[s].ack;
         bus_rsp_o.err = bus_rsp_o.err | slv_rsp_i[s].err;
      end
   end

   assert property (@(posedge clk) disable iff (rst_i) $onehot0(slv_stb))
      else $error("More than one slave strobed");

endmodule

/* src/wb_sram.sv */
/*
 * Local SRAM slave
 * Single-cycle Wishbone memory with byte selects, address wraps at
 * the memory size
 */
`timescale 1ns/100ps

module wb_sram (
   input  logic              clk,
   input  logic              rst_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   logic [tile_pkg::DATA_W-1:0]  mem [tile_pkg::LMEM_WORDS];
   logic [tile_pkg::LMEM_AW-1:0] idx;
   logic                         hit;
   logic                         ack_q;
   logic [tile_pkg::DATA_W-1:0]  dat_q;

   assign idx = req_i.adr[tile_pkg::LMEM_AW+1:2]; // Word index
   assign hit = req_i.cyc & req_i.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= hit;
      end
   end

   // Byte lanes written only where sel is set
   always_ff @(posedge clk) begin
      if (hit && req_i.we) begin
         for (int b = 0; b < tile_pkg::SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hit && !req_i.we) begin
         dat_q <= mem[idx];
      end
   end

   always_comb begin
      rsp_o     = '0;
      rsp_o.dat = dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0; // Memory always completes
   end

endmodule

/* src/wb_bootrom.sv */
/*
 * Boot ROM slave
 * Returns a tagged word per index, rejects writes with an error
 */
`timescale 1ns/100ps

module wb_bootrom (
   input  logic              clk,
   input  logic              rst_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   logic [tile_pkg::ROM_AW-1:0] idx;
   logic [tile_pkg::DATA_W-1:0] rom_word;
   logic                        hit;
   logic                        ack_q;
   logic                        err_q;
   logic [tile_pkg::DATA_W-1:0] dat_q;

   assign idx      = req_i.adr[tile_pkg::ROM_AW+1:2];
   assign rom_word = tile_pkg::ROM_TAG
                   + {{(tile_pkg::DATA_W-tile_pkg::ROM_AW){1'b0}}, idx};
   assign hit      = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= hit & ~req_i.we;
         err_q <= hit & req_i.we; // Read-only
      end
   end

   always_ff @(posedge clk) begin
      if (hit && !req_i.we) begin
         dat_q <= rom_word;
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

/* src/msg_adapter.sv */
/*
 * Message-passing network adapter
 * Register slave that pushes bus writes into a transmit FIFO towards the
 * NoC and pops received flits on reads, irq while receive data waits
 */
`timescale 1ns/100ps

module msg_adapter (
   input  logic              clk,
   input  logic              rst_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o,
   input  tile_pkg::flit_t   noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output tile_pkg::flit_t   noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,
   output logic              irq_o
);

   logic [3:0]                  reg_off;
   logic                        hit;
   logic                        tx_wr;
   logic                        rx_rd;
   logic                        bad;
   logic                        tx_full;
   logic                        tx_empty;
   logic                        rx_full;
   logic                        rx_empty;
   logic                        tx_push_q;
   tile_pkg::flit_t             tx_flit_q;
   tile_pkg::flit_t             rx_head;
   logic [tile_pkg::DATA_W-1:0] rd_data;
   logic                        ack_q;
   logic                        err_q;
   logic [tile_pkg::DATA_W-1:0] dat_q;

   assign reg_off = {req_i.adr[3:2], 2'b00};
   assign hit     = req_i.cyc & req_i.stb & ~(ack_q | err_q);
   assign tx_wr   = hit & req_i.we
                  & ((reg_off == tile_pkg::REG_TX) | (reg_off == tile_pkg::REG_TX_LAST));
   assign rx_rd   = hit & ~req_i.we & (reg_off == tile_pkg::REG_RX);
   assign bad     = (tx_wr & tx_full) | (rx_rd & rx_empty); // Full TX or empty RX

   always_comb begin
      case (reg_off)
         tile_pkg::REG_RX:     rd_data = rx_head.payload;
         tile_pkg::REG_STATUS: rd_data = {{(tile_pkg::DATA_W-3){1'b0}},
                                          rx_head.last, tx_full, ~rx_empty};
         default:              rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
         tx_push_q <= 1'b0;
      end else begin
         ack_q     <= hit & ~bad;
         err_q     <= hit & bad;
         tx_push_q <= tx_wr & ~tx_full; // Flit enters the FIFO after the ack
      end
   end

   always_ff @(posedge clk) begin
      tx_flit_q.last    <= (reg_off == tile_pkg::REG_TX_LAST);
      tx_flit_q.payload <= req_i.dat;
      if (hit && !req_i.we) begin
         dat_q <= rd_data;
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

   flit_fifo #(.DEPTH(tile_pkg::NA_FIFO_DEPTH)) u_tx_fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .push_i  (tx_push_q),
      .flit_i  (tx_flit_q),
      .full_o  (tx_full),
      .pop_i   (noc_out_ready_i & ~tx_empty),
      .flit_o  (noc_out_flit_o),
      .empty_o (tx_empty)
   );

   flit_fifo #(.DEPTH(tile_pkg::NA_FIFO_DEPTH)) u_rx_fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .push_i  (noc_in_valid_i & ~rx_full),
      .flit_i  (noc_in_flit_i),
      .full_o  (rx_full),
      .pop_i   (rx_rd & ~rx_empty),
      .flit_o  (rx_head),
      .empty_o (rx_empty)
   );

   assign noc_out_valid_o = ~tx_empty;
   assign noc_in_ready_o  = ~rx_full;
   assign irq_o           = ~rx_empty; // Received data waiting

endmodule

/* src/compute_tile.sv */
/*
 * Compute tile
 * Two Wishbone masters share one tile bus with local SRAM, the
 * message-passing network adapter and the boot ROM
 */
`timescale 1ns/100ps

module compute_tile (
   input  logic                                        clk,
   input  logic                                        rst_i,
   input  tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] m_req_i,
   output tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] m_rsp_o,
   input  tile_pkg::flit_t                             noc_in_flit_i,
   input  logic                                        noc_in_valid_i,
   output logic                                        noc_in_ready_o,
   output tile_pkg::flit_t                             noc_out_flit_o,
   output logic                                        noc_out_valid_o,
   input  logic                                        noc_out_ready_i,
   output logic                                        irq_o
);

   tile_pkg::wb_req_t                          bus_req;
   tile_pkg::wb_rsp_t                          bus_rsp;
   tile_pkg::wb_req_t [tile_pkg::NR_SLAVES-1:0] slv_req;
   tile_pkg::wb_rsp_t [tile_pkg::NR_SLAVES-1:0] slv_rsp;

   wb_arbiter u_arbiter (
      .clk       (clk),
      .rst_i     (rst_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_decoder u_decoder (
      .clk       (clk),
      .rst_i     (rst_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .slv_req_o (slv_req),
      .slv_rsp_i (slv_rsp)
   );

   wb_sram u_sram (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (slv_req[tile_pkg::SLV_SRAM]),
      .rsp_o (slv_rsp[tile_pkg::SLV_SRAM])
   );

   msg_adapter u_na (
      .clk             (clk),
      .rst_i           (rst_i),
      .req_i           (slv_req[tile_pkg::SLV_NA]),
      .rsp_o           (slv_rsp[tile_pkg::SLV_NA]),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

   wb_bootrom u_bootrom (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (slv_req[tile_pkg::SLV_ROM]),
      .rsp_o (slv_rsp[tile_pkg::SLV_ROM])
   );

endmodule

/* test/tb_compute_tile.sv */
/*
 * Compute tile testbench
 * Two Wishbone master drivers, a reference SRAM and NoC flit queues as
 * models, concurrent checks on response timing, reset state and irq
 */
`timescale 1ns/100ps

module tb_compute_tile;

   logic                                        clk;
   logic                                        rst;
   tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] m_req;
   tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] m_rsp;
   tile_pkg::flit_t                             noc_in_flit;
   logic                                        noc_in_valid;
   logic                                        noc_in_ready;
   tile_pkg::flit_t                             noc_out_flit;
   logic                                        noc_out_valid;
   logic                                        noc_out_ready;
   logic                                        irq;

   logic [31:0]     rng_state = 32'd66;
   logic [31:0]     ref_mem [tile_pkg::LMEM_WORDS]; // Reference SRAM
   tile_pkg::flit_t tx_exp [$];                     // Flits owed on noc_out
   tile_pkg::flit_t rx_exp [$];
   int              rx_cnt = 0;                     // Model receive FIFO fill
   int              issued [tile_pkg::NR_MASTERS] = '{0, 0};
   int              answered [tile_pkg::NR_MASTERS] = '{0, 0};
   int              checks = 0;
   int              errors = 0;
   int              cycles = 0;
   logic            check_latency = 1'b0;

   compute_tile DUT (
      .clk             (clk),
      .rst_i           (rst),
      .m_req_i         (m_req),
      .m_rsp_o         (m_rsp),
      .noc_in_flit_i   (noc_in_flit),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_flit_o  (noc_out_flit),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .irq_o           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Random upper bits above 1 KiB must alias to the same word
   function automatic logic [31:0] wrap_adr(input logic [7:0] idx);
      logic [31:0] rnd;
      rnd = next_random();
      return {1'b0, rnd[30:10], idx, 2'b00};
   endfunction

   function automatic logic [31:0] rom_adr(input logic [3:0] idx);
      return {tile_pkg::ROM_MATCH, 22'h0, idx, 2'b00};
   endfunction

   function automatic logic [31:0] na_adr(input logic [3:0] off);
      return {tile_pkg::NA_MATCH, 24'h0, off};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic count_mismatch(input string msg);
      errors++;
      $display("Mismatch at %0t: %s", $time, msg);
   endtask

   task automatic check_cond(input logic ok, input string msg);
      checks++;
      assert (ok === 1'b1) else count_mismatch(msg);
   endtask

   // Holds the request until ack or err, then leaves one idle cycle
   task automatic bus_access(input int m, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic we,
                             output logic [31:0] rdat, output logic ack, output logic err,
                             output int lat);
      tile_pkg::wb_req_t req;
      tile_pkg::flit_t   tx_f;
      logic              na_hit;
      req      = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      m_req[m] = req;
      lat      = 0;
      do begin
         @(posedge clk);
         #2;
         lat++;
      end while (!(m_rsp[m].ack || m_rsp[m].err));
      rdat     = m_rsp[m].dat;
      ack      = m_rsp[m].ack;
      err      = m_rsp[m].err;
      m_req[m] = '0;
      issued[m]++;
      na_hit   = ack && (adr[31:28] == tile_pkg::NA_MATCH);
      if (na_hit && we && (adr[3:0] == tile_pkg::REG_TX
                           || adr[3:0] == tile_pkg::REG_TX_LAST)) begin
         tx_f.last    = (adr[3:0] == tile_pkg::REG_TX_LAST);
         tx_f.payload = dat;
         tx_exp.push_back(tx_f);
      end
      if (na_hit && !we && adr[3:0] == tile_pkg::REG_RX) begin
         rx_cnt--; // Popped on the edge that raised ack
      end
      @(posedge clk);
      #2;
   endtask

   task automatic check_write(input int m, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, input logic exp_err);
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      int          lat;
      bus_access(m, adr, dat, sel, 1'b1, rdat, ack, err, lat);
      check_cond(exp_err ? (err && !ack) : (ack && !err),
                 $sformatf("master %0d write 0x%08h ack=%0b err=%0b", m, adr, ack, err));
      if (check_latency) begin
         check_cond(lat == 2, $sformatf("write latency %0d on an idle bus", lat));
      end
   endtask

   task automatic check_read(input int m, input logic [31:0] adr, input logic [31:0] exp,
                             input logic exp_err);
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      int          lat;
      bus_access(m, adr, '0, 4'hF, 1'b0, rdat, ack, err, lat);
      check_cond(exp_err ? (err && !ack) : (ack && !err),
                 $sformatf("master %0d read 0x%08h ack=%0b err=%0b", m, adr, ack, err));
      if (!exp_err) begin
         check_cond(rdat === exp, $sformatf("read 0x%08h got 0x%08h expected 0x%08h",
                                            adr, rdat, exp));
      end
      if (check_latency) begin
         check_cond(lat == 2, $sformatf("read latency %0d on an idle bus", lat));
      end
   endtask

   task automatic send_flit(input tile_pkg::flit_t f);
      logic took;
      noc_in_flit  = f;
      noc_in_valid = 1'b1;
      do begin
         took = noc_in_ready; // Ready is stable between edges
         @(posedge clk);
         #2;
      end while (!took);
      noc_in_valid = 1'b0;
   endtask

   task automatic wait_tx_drain();
      while (tx_exp.size() != 0) begin
         @(posedge clk);
         #2;
      end
      check_cond(!noc_out_valid, "noc_out still valid after all expected flits");
   endtask

   // Receive model and response counters
   always @(posedge clk) begin
      if (rst) begin
         rx_cnt <= 0;
      end else begin
         if (noc_in_valid && noc_in_ready) begin
            rx_cnt <= rx_cnt + 1;
            rx_exp.push_back(noc_in_flit);
         end
         for (int m = 0; m < tile_pkg::NR_MASTERS; m++) begin
            if (m_rsp[m].ack || m_rsp[m].err) begin
               answered[m]++;
            end
         end
      end
   end

   always @(posedge clk) begin
      tile_pkg::flit_t exp_f;
      if (!rst && noc_out_valid && noc_out_ready) begin
         if (tx_exp.size() == 0) begin
            count_mismatch("flit on noc_out with none expected");
         end else begin
            exp_f = tx_exp.pop_front();
            check_cond(noc_out_flit === exp_f,
                       $sformatf("noc_out flit %0b/0x%08h expected %0b/0x%08h",
                                 noc_out_flit.last, noc_out_flit.payload,
                                 exp_f.last, exp_f.payload));
         end
      end
   end

   // Limit is about four times the stimulus length
   always @(posedge clk) begin
      cycles++;
      if (cycles == 2000) begin
         $display("Timeout: the run did not finish within 2000 clock cycles");
         $display("Checks run: %0d, errors: %0d", checks, errors);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   for (genvar g = 0; g < tile_pkg::NR_MASTERS; g++) begin : gen_rsp_chk
      assert property (@(posedge clk) disable iff (rst)
         (m_rsp[g].ack || m_rsp[g].err) |=> !(m_rsp[g].ack || m_rsp[g].err))
         else count_mismatch($sformatf("master %0d response longer than one cycle", g));
   end

   assert property (@(posedge clk) rst |=> (m_rsp == '0 && !noc_out_valid && !irq
                                            && noc_in_ready && DUT.u_arbiter.grant_q == '0))
      else count_mismatch("outputs not at their reset values");

   assert property (@(posedge clk) disable iff (rst) irq == (rx_cnt != 0))
      else count_mismatch($sformatf("irq_o=%0b with %0d flits in the receive model",
                                    irq, rx_cnt));

   initial begin
      logic [31:0]     adr;
      logic [31:0]     dat;
      logic [31:0]     rnd;
      logic [31:0]     a0 [8];
      logic [31:0]     a1 [8];
      logic [31:0]     d0 [8];
      logic [31:0]     d1 [8];
      logic [31:0]     rdat;
      logic            ack;
      logic            err;
      int              lat;
      tile_pkg::flit_t f;

      m_req         = '0;
      noc_in_flit   = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b1;
      rst           = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;

      // SRAM with byte merge and 1 KiB aliasing, master 0 alone
      check_latency = 1'b1;
      for (int i = 0; i < 16; i++) begin
         adr = wrap_adr(i);
         dat = next_random();
         check_write(0, adr, dat, 4'hF, 1'b0);
         ref_mem[adr[9:2]] = dat;
      end
      for (int i = 0; i < 24; i++) begin
         rnd = next_random();
         adr = wrap_adr(rnd[3:0]);
         dat = next_random();
         check_write(0, adr, dat, rnd[7:4], 1'b0);
         ref_mem[adr[9:2]] = merge_bytes(ref_mem[adr[9:2]], dat, rnd[7:4]);
      end
      for (int i = 0; i < 16; i++) begin
         adr = wrap_adr(i);
         check_read(0, adr, ref_mem[adr[9:2]], 1'b0);
      end

      // Both masters contend for the bus
      check_latency = 1'b0;
      for (int i = 0; i < 8; i++) begin
         a0[i] = wrap_adr(32 + i);
         d0[i] = next_random();
         a1[i] = wrap_adr(48 + i);
         d1[i] = next_random();
      end
      fork
         begin
            for (int k = 0; k < 8; k++) begin
               check_write(0, a0[k], d0[k], 4'hF, 1'b0);
            end
            for (int k = 0; k < 8; k++) begin
               check_read(0, a0[k], d0[k], 1'b0);
            end
         end
         begin
            for (int k = 0; k < 8; k++) begin
               check_write(1, a1[k], d1[k], 4'hF, 1'b0);
            end
            for (int k = 0; k < 8; k++) begin
               check_read(1, a1[k], d1[k], 1'b0);
            end
         end
      join

      // Boot ROM and the unmapped hole
      check_latency = 1'b1;
      for (int i = 0; i < 4; i++) begin
         rnd = next_random();
         check_read(0, rom_adr(rnd[3:0]), tile_pkg::ROM_TAG + rnd[3:0], 1'b0);
      end
      check_write(1, rom_adr(4'd3), next_random(), 4'hF, 1'b1);
      check_read(0, 32'h8000_0000, '0, 1'b1);

      // Transmit path, then back-pressure until full
      for (int i = 0; i < 3; i++) begin
         check_write(0, na_adr(i == 2 ? tile_pkg::REG_TX_LAST : tile_pkg::REG_TX),
                     next_random(), 4'hF, 1'b0);
      end
      wait_tx_drain();
      noc_out_ready = 1'b0;
      for (int i = 0; i < tile_pkg::NA_FIFO_DEPTH; i++) begin
         check_write(0, na_adr(i == 3 ? tile_pkg::REG_TX_LAST : tile_pkg::REG_TX),
                     next_random(), 4'hF, 1'b0);
      end
      bus_access(0, na_adr(tile_pkg::REG_STATUS), '0, 4'hF, 1'b0, rdat, ack, err, lat);
      check_cond(ack && rdat[1:0] == 2'b10, $sformatf("status 0x%08h with full TX", rdat));
      check_write(0, na_adr(tile_pkg::REG_TX), next_random(), 4'hF, 1'b1);
      noc_out_ready = 1'b1;
      wait_tx_drain();

      // Receive path, head flit carries last
      for (int i = 0; i < 3; i++) begin
         f.last    = (i != 1);
         f.payload = next_random();
         send_flit(f);
      end
      check_cond(irq === 1'b1, "irq_o low with received flits waiting");
      bus_access(0, na_adr(tile_pkg::REG_STATUS), '0, 4'hF, 1'b0, rdat, ack, err, lat);
      check_cond(ack && rdat[2:0] == 3'b101, $sformatf("status 0x%08h with RX data", rdat));
      for (int i = 0; i < 3; i++) begin
         f = rx_exp.pop_front();
         check_read(0, na_adr(tile_pkg::REG_RX), f.payload, 1'b0);
      end
      check_cond(irq === 1'b0, "irq_o still high after the last pop");
      check_read(0, na_adr(tile_pkg::REG_RX), '0, 1'b1);

      repeat (2) @(posedge clk);
      for (int m = 0; m < tile_pkg::NR_MASTERS; m++) begin
         check_cond(issued[m] == answered[m],
                    $sformatf("master %0d issued %0d requests, saw %0d responses",
                              m, issued[m], answered[m]));
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
src/tile_pkg.sv
src/flit_fifo.sv
src/wb_arbiter.sv
src/wb_decoder.sv
src/wb_sram.sv
src/wb_bootrom.sv
src/msg_adapter.sv
src/compute_tile.sv
test/tb_compute_tile.sv
